// File: source/periph_pkg.sv
`default_nettype none

package periph_pkg;

    // --------------------
    // Bus widths and counts
    // --------------------
    localparam int AddrWidth  = 16;
    localparam int DataWidth  = 32;
    localparam int NumTimers  = 2;
    localparam int NumExtIrq  = 2;
    // Ids 1..2 are the timers, ids 3..4 the external lines
    localparam int NumSources = NumTimers + NumExtIrq;
    localparam int PrioWidth  = 3;
    localparam int SrcIdWidth = 3;

    // --------------------
    // Address map
    // --------------------
    // Region field is paddr[15:12], the slaves see the low 12 bits
    localparam int RegionLsb = 12;
    localparam logic [AddrWidth-RegionLsb-1:0] RegionPlic  = 4'd0;
    localparam logic [AddrWidth-RegionLsb-1:0] RegionTimer = 4'd1;
    localparam logic [DataWidth-1:0] ErrData = 32'hdeadbeef;

    // --------------------
    // PLIC register offsets
    // --------------------
    localparam logic [RegionLsb-1:0] PlicPrioBase     = 12'h000;
    localparam logic [RegionLsb-1:0] PlicPendingOff   = 12'h080;
    localparam logic [RegionLsb-1:0] PlicEnableOff    = 12'h100;
    localparam logic [RegionLsb-1:0] PlicThresholdOff = 12'h200;
    localparam logic [RegionLsb-1:0] PlicClaimOff     = 12'h204;

    // --------------------
    // Timer register offsets
    // --------------------
    localparam logic [RegionLsb-1:0] TimerStride    = 12'h010;
    localparam logic [RegionLsb-1:0] TimerCtrlOff   = 12'h000;
    localparam logic [RegionLsb-1:0] TimerCountOff  = 12'h004;
    localparam logic [RegionLsb-1:0] TimerCmpOff    = 12'h008;
    localparam logic [RegionLsb-1:0] TimerStatusOff = 12'h00c;

endpackage

`default_nettype wire

// File: source/periph_plic_arbiter.sv
`default_nettype none

module periph_plic_arbiter
    import periph_pkg::*;
(
    input  logic [PrioWidth-1:0]  prio_i [NumSources],
    // Pending and enabled
    input  logic [NumSources-1:0] active_i,
    output logic [SrcIdWidth-1:0] best_id_o,
    output logic [PrioWidth-1:0]  best_prio_o
);

    // --------------------
    // Priority search
    // --------------------
    // Strict compare, so on equal priority the lower id stays.
    // Starting from zero also drops sources with priority 0
    always_comb begin
        best_id_o   = '0;
        best_prio_o = '0;
        for (int k = 0; k < NumSources; k++) begin
            if (active_i[k] && (prio_i[k] > best_prio_o)) begin
                best_id_o   = SrcIdWidth'(k + 1);
                best_prio_o = prio_i[k];
            end
        end
    end

endmodule

`default_nettype wire

// File: source/periph_plic.sv
`default_nettype none

module periph_plic
    import periph_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  psel_i,
    input  logic                  penable_i,
    input  logic                  pwrite_i,
    input  logic [RegionLsb-1:0]  paddr_i,
    input  logic [DataWidth-1:0]  pwdata_i,
    output logic [DataWidth-1:0]  prdata_o,
    output logic                  pready_o,
    output logic                  pslverr_o,
    input  logic [NumSources-1:0] irq_src_i,
    output logic                  irq_o
);

    // Bit k of every vector is source id k+1
    logic [PrioWidth-1:0]  prio_q [NumSources];
    logic [NumSources-1:0] enable_q;
    logic [NumSources-1:0] pending_q;
    logic [NumSources-1:0] inserv_q;
    logic [PrioWidth-1:0]  threshold_q;

    logic [SrcIdWidth-1:0] best_id;
    logic [PrioWidth-1:0]  best_prio;

    logic                  access;
    logic                  wr;
    logic [NumSources-1:0] prio_sel;
    logic                  off_pending;
    logic                  off_enable;
    logic                  off_thresh;
    logic                  off_claim;
    logic                  off_ok;
    logic [NumSources-1:0] claim_mask;
    logic [NumSources-1:0] complete_mask;

    assign access = psel_i & penable_i;
    assign wr     = access & pwrite_i;

    // --------------------
    // Offset decode
    // --------------------
    assign off_pending = (paddr_i == PlicPendingOff);
    assign off_enable  = (paddr_i == PlicEnableOff);
    assign off_thresh  = (paddr_i == PlicThresholdOff);
    assign off_claim   = (paddr_i == PlicClaimOff);

    // Claim on read, complete on write of an id
    always_comb begin
        for (int k = 0; k < NumSources; k++) begin
            prio_sel[k]      = (paddr_i == PlicPrioBase + RegionLsb'(4 * (k + 1)));
            claim_mask[k]    = access && !pwrite_i && off_claim &&
                               (best_id == SrcIdWidth'(k + 1));
            complete_mask[k] = wr && off_claim &&
                               (pwdata_i[SrcIdWidth-1:0] == SrcIdWidth'(k + 1));
        end
    end

    // Pending is read-only
    assign off_ok    = (|prio_sel) || off_enable || off_thresh || off_claim ||
                       (off_pending && !pwrite_i);
    assign pready_o  = access;
    assign pslverr_o = access & ~off_ok;

    // --------------------
    // Registers and gateways
    // --------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            enable_q    <= '0;
            pending_q   <= '0;
            inserv_q    <= '0;
            threshold_q <= '0;
            for (int k = 0; k < NumSources; k++) begin
                prio_q[k] <= '0;
            end
        end else begin
            for (int k = 0; k < NumSources; k++) begin
                if (wr && prio_sel[k]) begin
                    prio_q[k] <= pwdata_i[PrioWidth-1:0];
                end
            end
            if (wr && off_enable) begin
                enable_q <= pwdata_i[NumSources:1];
            end
            if (wr && off_thresh) begin
                threshold_q <= pwdata_i[PrioWidth-1:0];
            end
            // Level gateway, blocked while the source is in service
            pending_q <= (pending_q | (irq_src_i & ~inserv_q)) & ~claim_mask;
            inserv_q  <= (inserv_q | claim_mask) & ~complete_mask;
        end
    end

    periph_plic_arbiter arbiter_inst (
        .prio_i      (prio_q),
        .active_i    (pending_q & enable_q),
        .best_id_o   (best_id),
        .best_prio_o (best_prio)
    );

    assign irq_o = (best_prio > threshold_q);

    // Read data
    always_comb begin
        prdata_o = '0;
        for (int k = 0; k < NumSources; k++) begin
            if (prio_sel[k]) begin
                prdata_o = DataWidth'(prio_q[k]);
            end
        end
        if (off_pending) begin
            prdata_o = DataWidth'({pending_q, 1'b0});
        end else if (off_enable) begin
            prdata_o = DataWidth'({enable_q, 1'b0});
        end else if (off_thresh) begin
            prdata_o = DataWidth'(threshold_q);
        end else if (off_claim) begin
            prdata_o = DataWidth'(best_id);
        end
    end

endmodule

`default_nettype wire

// File: source/periph_timer.sv
`default_nettype none

module periph_timer
    import periph_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 psel_i,
    input  logic                 penable_i,
    input  logic                 pwrite_i,
    input  logic [RegionLsb-1:0] paddr_i,
    input  logic [DataWidth-1:0] pwdata_i,
    output logic [DataWidth-1:0] prdata_o,
    output logic                 pready_o,
    output logic                 pslverr_o,
    output logic [NumTimers-1:0] timer_irq_o
);

    logic [NumTimers-1:0] en_q;
    logic [NumTimers-1:0] status_q;
    logic [DataWidth-1:0] count_q [NumTimers];
    logic [DataWidth-1:0] cmp_q   [NumTimers];

    logic [RegionLsb-1:0] timer_idx;
    logic [RegionLsb-1:0] reg_off;
    logic                 access;
    logic                 wr;
    logic                 off_ok;

    logic [NumTimers-1:0] timer_hit;
    logic [NumTimers-1:0] match;
    logic [NumTimers-1:0] wr_ctrl;
    logic [NumTimers-1:0] wr_count;
    logic [NumTimers-1:0] wr_cmp;
    logic [NumTimers-1:0] wr_status;

    assign timer_idx = paddr_i / TimerStride;
    assign reg_off   = paddr_i % TimerStride;
    assign access    = psel_i & penable_i;
    assign wr        = access & pwrite_i;

    assign off_ok = (timer_idx < RegionLsb'(NumTimers)) &&
                    ((reg_off == TimerCtrlOff) || (reg_off == TimerCountOff) ||
                     (reg_off == TimerCmpOff)  || (reg_off == TimerStatusOff));

    assign pready_o    = access;
    assign pslverr_o   = access & ~off_ok;
    assign timer_irq_o = status_q;

    // Per-timer decode and compare match
    always_comb begin
        for (int i = 0; i < NumTimers; i++) begin
            timer_hit[i] = (timer_idx == RegionLsb'(i));
            match[i]     = en_q[i] && (count_q[i] == cmp_q[i]);
            wr_ctrl[i]   = wr && timer_hit[i] && (reg_off == TimerCtrlOff);
            wr_count[i]  = wr && timer_hit[i] && (reg_off == TimerCountOff);
            wr_cmp[i]    = wr && timer_hit[i] && (reg_off == TimerCmpOff);
            wr_status[i] = wr && timer_hit[i] && (reg_off == TimerStatusOff);
        end
    end

    // --------------------
    // Timer registers
    // --------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            en_q     <= '0;
            status_q <= '0;
            for (int i = 0; i < NumTimers; i++) begin
                count_q[i] <= '0;
                cmp_q[i]   <= '0;
            end
        end else begin
            for (int i = 0; i < NumTimers; i++) begin
                if (wr_ctrl[i]) begin
                    en_q[i] <= pwdata_i[0];
                end
                if (wr_cmp[i]) begin
                    cmp_q[i] <= pwdata_i;
                end
                // A bus load beats the wrap on match
                if (wr_count[i]) begin
                    count_q[i] <= pwdata_i;
                end else if (match[i]) begin
                    count_q[i] <= '0;
                end else if (en_q[i]) begin
                    count_q[i] <= count_q[i] + 1'b1;
                end
                // Sticky, a new match wins over write-one-to-clear
                if (match[i]) begin
                    status_q[i] <= 1'b1;
                end else if (wr_status[i] && pwdata_i[0]) begin
                    status_q[i] <= 1'b0;
                end
            end
        end
    end

    // Read data
    always_comb begin
        prdata_o = '0;
        for (int i = 0; i < NumTimers; i++) begin
            if (timer_hit[i]) begin
                case (reg_off)
                    TimerCtrlOff:   prdata_o = DataWidth'(en_q[i]);
                    TimerCountOff:  prdata_o = count_q[i];
                    TimerCmpOff:    prdata_o = cmp_q[i];
                    TimerStatusOff: prdata_o = DataWidth'(status_q[i]);
                    default:        prdata_o = '0;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: source/periph_apb_demux.sv
`default_nettype none

module periph_apb_demux
    import periph_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    // Master side
    input  logic                 psel_i,
    input  logic                 penable_i,
    input  logic                 pwrite_i,
    input  logic [AddrWidth-1:0] paddr_i,
    input  logic [DataWidth-1:0] pwdata_i,
    output logic [DataWidth-1:0] prdata_o,
    output logic                 pready_o,
    output logic                 pslverr_o,
    // Slave side
    output logic                 plic_psel_o,
    output logic                 timer_psel_o,
    output logic                 slv_penable_o,
    output logic                 slv_pwrite_o,
    output logic [RegionLsb-1:0] slv_paddr_o,
    output logic [DataWidth-1:0] slv_pwdata_o,
    input  logic [DataWidth-1:0] plic_prdata_i,
    input  logic [DataWidth-1:0] timer_prdata_i,
    input  logic                 plic_pready_i,
    input  logic                 timer_pready_i,
    input  logic                 plic_pslverr_i,
    input  logic                 timer_pslverr_i
);

    logic [AddrWidth-RegionLsb-1:0] region;
    logic                           hit_plic;
    logic                           hit_timer;
    logic                           access;

    assign region    = paddr_i[AddrWidth-1:RegionLsb];
    assign hit_plic  = (region == RegionPlic);
    assign hit_timer = (region == RegionTimer);
    assign access    = psel_i & penable_i;

    // --------------------
    // Request routing
    // --------------------
    assign plic_psel_o   = psel_i & hit_plic;
    assign timer_psel_o  = psel_i & hit_timer;
    assign slv_penable_o = penable_i;
    assign slv_pwrite_o  = pwrite_i;
    assign slv_paddr_o   = paddr_i[RegionLsb-1:0];
    assign slv_pwdata_o  = pwdata_i;

    // --------------------
    // Response mux
    // --------------------
    always_comb begin
        if (hit_plic) begin
            prdata_o  = plic_prdata_i;
            pready_o  = plic_pready_i;
            pslverr_o = plic_pslverr_i;
        end else if (hit_timer) begin
            prdata_o  = timer_prdata_i;
            pready_o  = timer_pready_i;
            pslverr_o = timer_pslverr_i;
        end else begin
            // Unmapped region answers on its own
            prdata_o  = ErrData;
            pready_o  = access;
            pslverr_o = access;
        end
    end

endmodule

`default_nettype wire

// File: source/periph_top.sv
`default_nettype none

module periph_top
    import periph_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 psel_i,
    input  logic                 penable_i,
    input  logic                 pwrite_i,
    input  logic [AddrWidth-1:0] paddr_i,
    input  logic [DataWidth-1:0] pwdata_i,
    output logic [DataWidth-1:0] prdata_o,
    output logic                 pready_o,
    output logic                 pslverr_o,
    input  logic [NumExtIrq-1:0] irq_ext_i,
    output logic                 irq_o
);

    // Shared slave side of the bus
    logic                 slv_penable;
    logic                 slv_pwrite;
    logic [RegionLsb-1:0] slv_paddr;
    logic [DataWidth-1:0] slv_pwdata;

    logic                 plic_psel;
    logic [DataWidth-1:0] plic_prdata;
    logic                 plic_pready;
    logic                 plic_pslverr;

    logic                 timer_psel;
    logic [DataWidth-1:0] timer_prdata;
    logic                 timer_pready;
    logic                 timer_pslverr;

    logic [NumTimers-1:0] timer_irq;

    periph_apb_demux demux_inst (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .psel_i          (psel_i),
        .penable_i       (penable_i),
        .pwrite_i        (pwrite_i),
        .paddr_i         (paddr_i),
        .pwdata_i        (pwdata_i),
        .prdata_o        (prdata_o),
        .pready_o        (pready_o),
        .pslverr_o       (pslverr_o),
        .plic_psel_o     (plic_psel),
        .timer_psel_o    (timer_psel),
        .slv_penable_o   (slv_penable),
        .slv_pwrite_o    (slv_pwrite),
        .slv_paddr_o     (slv_paddr),
        .slv_pwdata_o    (slv_pwdata),
        .plic_prdata_i   (plic_prdata),
        .timer_prdata_i  (timer_prdata),
        .plic_pready_i   (plic_pready),
        .timer_pready_i  (timer_pready),
        .plic_pslverr_i  (plic_pslverr),
        .timer_pslverr_i (timer_pslverr)
    );

    // Sources 1..2 are the timers, 3..4 the external lines
    periph_plic plic_inst (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .psel_i    (plic_psel),
        .penable_i (slv_penable),
        .pwrite_i  (slv_pwrite),
        .paddr_i   (slv_paddr),
        .pwdata_i  (slv_pwdata),
        .prdata_o  (plic_prdata),
        .pready_o  (plic_pready),
        .pslverr_o (plic_pslverr),
        .irq_src_i ({irq_ext_i, timer_irq}),
        .irq_o     (irq_o)
    );

    periph_timer timer_inst (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .psel_i      (timer_psel),
        .penable_i   (slv_penable),
        .pwrite_i    (slv_pwrite),
        .paddr_i     (slv_paddr),
        .pwdata_i    (slv_pwdata),
        .prdata_o    (timer_prdata),
        .pready_o    (timer_pready),
        .pslverr_o   (timer_pslverr),
        .timer_irq_o (timer_irq)
    );

endmodule

`default_nettype wire

// File: test/periph_props.sv
`default_nettype none

module periph_props (
    input logic clk_i,
    input logic rst_n_i,
    input logic psel_i,
    input logic penable_i,
    input logic pready_i,
    input logic pslverr_i,
    input logic irq_i
);

    // Number of failed assertions
    int error_count = 0;

    // No wait states on any slave or on the error region
    pready_in_access: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (psel_i && penable_i) |-> pready_i)
        else begin
            $error("pready_o was low during an APB access phase");
            error_count++;
        end

    pslverr_only_in_access: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(psel_i && penable_i) |-> !pslverr_i)
        else begin
            $error("pslverr_o was high outside an APB access phase");
            error_count++;
        end

    // Registers clear at the reset edge, so the line is low one sample later
    irq_low_in_reset: assert property (@(posedge clk_i)
        $past(!rst_n_i) |-> !irq_i)
        else begin
            $error("irq_o was high while reset was applied");
            error_count++;
        end

endmodule

bind periph_top periph_props props_inst (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pready_i  (pready_o),
    .pslverr_i (pslverr_o),
    .irq_i     (irq_o)
);

`default_nettype wire

// File: test/periph_tb.sv
`default_nettype none

module periph_tb
    import periph_pkg::*;
();

    localparam logic [31:0] LfsrSeed = 32'h8221262a;
    localparam logic [31:0] LfsrTaps = 32'h80200003;
    // About 120 transfers of 2 cycles plus short timer polls need a few hundred cycles
    localparam int MaxCycles = 20000;

    localparam int ChkNone    = 0;
    localparam int ChkData    = 1;
    localparam int ChkClaim   = 2;
    localparam int ChkPending = 3;

    logic                 clk = 1'b0;
    logic                 rst_n;
    logic                 psel;
    logic                 penable;
    logic                 pwrite;
    logic [AddrWidth-1:0] paddr;
    logic [DataWidth-1:0] pwdata;
    logic [DataWidth-1:0] prdata;
    logic                 pready;
    logic                 pslverr;
    logic [NumExtIrq-1:0] irq_ext;
    logic                 irq;

    // Shadow model with PLIC vectors indexed by source id
    logic [PrioWidth-1:0]  m_prio [1:NumSources];
    logic [NumSources:1]   m_enable;
    logic [NumSources:1]   m_pending;
    logic [NumSources:1]   m_inserv;
    logic [NumSources:1]   m_src;
    logic [PrioWidth-1:0]  m_thresh;
    logic [DataWidth-1:0]  m_tcmp [NumTimers];
    logic [NumTimers-1:0]  m_tctrl;

    logic [31:0]          lfsr = LfsrSeed;
    logic                 chk_req = 1'b0;
    int                   chk_kind;
    logic [DataWidth-1:0] exp_data;
    logic                 exp_err;
    logic [DataWidth-1:0] rd_data;
    int                   cycles = 0;

    periph_top periph_top_inst (
        .clk_i     (clk),
        .rst_n_i   (rst_n),
        .psel_i    (psel),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .paddr_i   (paddr),
        .pwdata_i  (pwdata),
        .prdata_o  (prdata),
        .pready_o  (pready),
        .pslverr_o (pslverr),
        .irq_ext_i (irq_ext),
        .irq_o     (irq)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MaxCycles) begin
            $display("Timeout: the test did not finish within %0d cycles", MaxCycles);
            $display("Done: errors found");
            $fatal(1);
        end
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int b = 0; b < n; b++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ LfsrTaps) : (lfsr >> 1);
        end
        return val;
    endfunction

    // Returns {best priority, best id} and walks down so the lower id wins a tie
    function automatic logic [5:0] expected_claim(input logic [NumSources:1] active);
        logic [2:0] id;
        logic [2:0] prio;
        id   = '0;
        prio = '0;
        for (int s = NumSources; s >= 1; s--) begin
            if (active[s] && (m_prio[s] != 0) && (m_prio[s] >= prio)) begin
                id   = 3'(s);
                prio = m_prio[s];
            end
        end
        return {prio, id};
    endfunction

    function automatic logic [AddrWidth-1:0] plic_addr(input logic [RegionLsb-1:0] off);
        return {RegionPlic, off};
    endfunction

    function automatic logic [AddrWidth-1:0] timer_addr(input int t,
                                                         input logic [RegionLsb-1:0] off);
        return {RegionTimer, RegionLsb'(t) * TimerStride + off};
    endfunction

    task automatic report_error(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        $display("error at time %0t: %s is %h, expected %h", $time, name, got, exp);
        $display("Done: errors found");
        $fatal(1);
    endtask

    // --------------------
    // Compare process
    // --------------------
    always @(negedge clk) begin : compare_bus
        logic [5:0] best;
        logic       exp_irq;
        if (chk_req) begin
            m_pending = m_pending | (m_src & ~m_inserv);
            best      = expected_claim(m_pending & m_enable);
            exp_irq   = (best[5:3] > m_thresh);
            assert (pready === 1'b1) else report_error("pready_o", 32'(pready), 32'd1);
            assert (pslverr === exp_err)
                else report_error("pslverr_o", 32'(pslverr), 32'(exp_err));
            assert (irq === exp_irq) else report_error("irq_o", 32'(irq), 32'(exp_irq));
            case (chk_kind)
                ChkData: begin
                    assert (prdata === exp_data) else report_error("prdata_o", prdata, exp_data);
                end
                ChkPending: begin
                    assert (prdata === 32'({m_pending, 1'b0}))
                        else report_error("prdata_o", prdata, 32'({m_pending, 1'b0}));
                end
                ChkClaim: begin
                    assert (prdata === 32'(best[2:0]))
                        else report_error("prdata_o", prdata, 32'(best[2:0]));
                    if (best[2:0] != 3'd0) begin
                        m_pending[best[2:0]] = 1'b0;
                        m_inserv[best[2:0]]  = 1'b1;
                    end
                end
                default: begin
                end
            endcase
            rd_data = prdata;
            chk_req = 1'b0;
        end
    end

    // Setup then access while the compare process samples the access phase
    task automatic apb_transfer(input logic wr, input logic [AddrWidth-1:0] addr,
                                input logic [DataWidth-1:0] data, input int kind,
                                input logic [DataWidth-1:0] exp, input logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable  <= 1'b1;
        chk_kind = kind;
        exp_data = exp;
        exp_err  = err;
        chk_req  = 1'b1;
        wait (chk_req == 1'b0);
    endtask

    task automatic write_reg(input logic [AddrWidth-1:0] addr, input logic [DataWidth-1:0] data);
        apb_transfer(1'b1, addr, data, ChkNone, '0, 1'b0);
    endtask

    task automatic read_expect(input logic [AddrWidth-1:0] addr,
                               input logic [DataWidth-1:0] exp);
        apb_transfer(1'b0, addr, '0, ChkData, exp, 1'b0);
    endtask

    task automatic read_claim();
        apb_transfer(1'b0, plic_addr(PlicClaimOff), '0, ChkClaim, '0, 1'b0);
    endtask

    task automatic read_pending();
        apb_transfer(1'b0, plic_addr(PlicPendingOff), '0, ChkPending, '0, 1'b0);
    endtask

    // Also leaves the bus idle for one cycle
    task automatic drive_ext(input logic [NumExtIrq-1:0] lines);
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        irq_ext <= lines;
    endtask

    task automatic check_registers();
        for (int s = 1; s <= NumSources; s++) begin
            read_expect(plic_addr(PlicPrioBase + RegionLsb'(4 * s)), 32'(m_prio[s]));
        end
        read_expect(plic_addr(PlicEnableOff), 32'({m_enable, 1'b0}));
        read_expect(plic_addr(PlicThresholdOff), 32'(m_thresh));
        for (int t = 0; t < NumTimers; t++) begin
            read_expect(timer_addr(t, TimerCmpOff), m_tcmp[t]);
            read_expect(timer_addr(t, TimerCtrlOff), 32'(m_tctrl[t]));
        end
    endtask

    initial begin : stimulus
        logic [31:0]          val;
        logic [3:0]           region;
        logic [RegionLsb-1:0] off;
        psel      <= 1'b0;
        penable   <= 1'b0;
        pwrite    <= 1'b0;
        paddr     <= '0;
        pwdata    <= '0;
        irq_ext   <= '0;
        rst_n     <= 1'b0;
        m_enable  = '0;
        m_pending = '0;
        m_inserv  = '0;
        m_src     = '0;
        m_thresh  = '0;
        m_tctrl   = '0;
        for (int s = 1; s <= NumSources; s++) begin
            m_prio[s] = '0;
        end
        for (int t = 0; t < NumTimers; t++) begin
            m_tcmp[t] = '0;
        end
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        // --------------------
        // Register readback
        // --------------------
        for (int s = 1; s <= NumSources; s++) begin
            val = rand_bits(PrioWidth);
            write_reg(plic_addr(PlicPrioBase + RegionLsb'(4 * s)), val);
            m_prio[s] = val[PrioWidth-1:0];
        end
        val = rand_bits(DataWidth);
        write_reg(plic_addr(PlicEnableOff), val);
        m_enable = val[NumSources:1];
        val = rand_bits(PrioWidth);
        write_reg(plic_addr(PlicThresholdOff), val);
        m_thresh = val[PrioWidth-1:0];
        // Compare kept far above the run length so no match fires here
        for (int t = 0; t < NumTimers; t++) begin
            val = rand_bits(DataWidth) | 32'h8000_0000;
            write_reg(timer_addr(t, TimerCmpOff), val);
            m_tcmp[t] = val;
            val = rand_bits(1);
            write_reg(timer_addr(t, TimerCtrlOff), val);
            m_tctrl[t] = val[0];
        end
        check_registers();
        for (int t = 0; t < NumTimers; t++) begin
            write_reg(timer_addr(t, TimerCtrlOff), '0);
            m_tctrl[t] = 1'b0;
        end

        // --------------------
        // Unmapped regions
        // --------------------
        for (int n = 0; n < 8; n++) begin
            region = 4'(rand_bits(4));
            if (region < 4'd2) begin
                region = region + 4'd2;
            end
            case (rand_bits(2))
                0: off = PlicEnableOff;
                1: off = PlicThresholdOff;
                2: off = TimerCmpOff;
                default: off = PlicPrioBase + 12'h004;
            endcase
            apb_transfer(1'b0, {region, off}, '0, ChkData, ErrData, 1'b1);
            apb_transfer(1'b1, {region, off}, rand_bits(DataWidth), ChkNone, '0, 1'b1);
        end
        check_registers();

        // --------------------
        // Claims from external lines
        // --------------------
        for (int s = 1; s <= NumSources; s++) begin
            val = rand_bits(PrioWidth) | 32'd1;
            write_reg(plic_addr(PlicPrioBase + RegionLsb'(4 * s)), val);
            m_prio[s] = val[PrioWidth-1:0];
        end
        val = rand_bits(DataWidth);
        write_reg(plic_addr(PlicEnableOff), val);
        m_enable = val[NumSources:1];
        val = rand_bits(2);
        write_reg(plic_addr(PlicThresholdOff), val);
        m_thresh = val[PrioWidth-1:0];
        drive_ext(2'b11);
        m_src[4:3] = 2'b11;
        repeat (3) read_claim();
        read_pending();

        // In service sources stay out until completed
        write_reg(plic_addr(PlicEnableOff), 32'h1e);
        m_enable = '1;
        write_reg(plic_addr(PlicThresholdOff), '0);
        m_thresh = '0;
        repeat (3) read_claim();
        for (int id = 3; id <= NumSources; id++) begin
            write_reg(plic_addr(PlicClaimOff), 32'(id));
            m_inserv[id] = 1'b0;
            read_pending();
            read_claim();
        end
        drive_ext(2'b00);
        m_src[4:3] = 2'b00;
        for (int id = 3; id <= NumSources; id++) begin
            write_reg(plic_addr(PlicClaimOff), 32'(id));
            m_inserv[id] = 1'b0;
        end
        read_pending();
        read_claim();

        // --------------------
        // Timer interrupts
        // --------------------
        // Threshold at maximum hides irq_o while the match time is unknown
        write_reg(plic_addr(PlicThresholdOff), 32'd7);
        m_thresh = 3'd7;
        for (int t = 0; t < NumTimers; t++) begin
            write_reg(timer_addr(t, TimerCountOff), '0);
            val = rand_bits(3) + 32'd3;
            write_reg(timer_addr(t, TimerCmpOff), val);
            m_tcmp[t] = val;
            write_reg(timer_addr(t, TimerCtrlOff), 32'd1);
            m_tctrl[t] = 1'b1;
            do begin
                apb_transfer(1'b0, timer_addr(t, TimerStatusOff), '0, ChkNone, '0, 1'b0);
            end while (rd_data[0] == 1'b0);
            m_src[t+1] = 1'b1;
            write_reg(timer_addr(t, TimerCtrlOff), '0);
            m_tctrl[t] = 1'b0;
            read_pending();
            write_reg(plic_addr(PlicThresholdOff), '0);
            m_thresh = '0;
            read_claim();
            write_reg(timer_addr(t, TimerStatusOff), 32'd1);
            m_src[t+1] = 1'b0;
            read_expect(timer_addr(t, TimerStatusOff), '0);
            write_reg(plic_addr(PlicClaimOff), 32'(t + 1));
            m_inserv[t+1] = 1'b0;
            read_pending();
            write_reg(plic_addr(PlicThresholdOff), 32'd7);
            m_thresh = 3'd7;
        end
        check_registers();

        drive_ext(2'b00);
        if (periph_top_inst.props_inst.error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
source/periph_pkg.sv
source/periph_plic_arbiter.sv
source/periph_plic.sv
source/periph_timer.sv
source/periph_apb_demux.sv
source/periph_top.sv
test/periph_props.sv
test/periph_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= periph_tb
BUILD_DIR ?= obj_dir
FILELIST  ?= sim.f
LOG       ?= sim.log
PASS_MSG  ?= Done: no errors
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides the result, the simulator status is ignored
run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
